//--- design/tlb_cfg.svh
`ifndef TLB_CFG_SVH
`define TLB_CFG_SVH

// ============================================================
// Translation buffer geometry
// ============================================================
`define TLB_ENTRIES    128          // Entries held in each of the two ways
`define TLB_IDX_W      7            // Width of an entry index
`define VADDR_W        32
`define TAG_LSB        23           // Tag is vaddr[31:23]
`define IDX_LSB        16           // Index is vaddr[22:16], page offset below
`define PPN_W          16
`define ASID_W         8
`define ROB_W          6

// Miss queue sizing, depth must stay a power of two
`define MISSQ_DEPTH    16
`define MISSQ_PTR_W    4

// Boot mapping of the top of the address space into way 0
`define PRELOAD_FIRST  116
`define PRELOAD_COUNT  12
`define PRELOAD_PPN    16'hfff4

`endif

//--- design/tlb_pkg.sv
`include "tlb_cfg.svh"

package tlb_pkg;

  // ============================================================
  // Scalar types
  // ============================================================
  typedef logic [`VADDR_W-1:0]          vaddr_t;
  typedef logic [`VADDR_W-`TAG_LSB-1:0] tag_t;     // Upper virtual bits kept per entry
  typedef logic [`TLB_IDX_W-1:0]        idx_t;
  typedef logic [`PPN_W-1:0]            ppn_t;
  typedef logic [`PPN_W+`IDX_LSB-1:0]   paddr_t;   // Page number above the page offset
  typedef logic [`ASID_W-1:0]           asid_t;
  typedef logic [`ROB_W-1:0]            rob_ndx_t;
  typedef logic [2:0]                   rwx_t;

  // One translation as stored in a way
  typedef struct packed {
    logic  valid;
    tag_t  tag;
    asid_t asid;
    ppn_t  ppn;
    rwx_t  rwx;
  } tlb_entry_t;

  // Write into one way, used both for maintenance and for the boot preload
  typedef struct packed {
    logic       we;
    logic       way;                                // 0 selects way 0, 1 selects way 1
    idx_t       idx;
    tlb_entry_t entry;
  } tlb_wr_t;

  typedef struct packed {
    logic     valid;
    vaddr_t   vaddr;
    asid_t    asid;
    rob_ndx_t rob_ndx;                              // Travels with the lookup to the result
  } lookup_req_t;

  // What the page walker receives for a missed page
  typedef struct packed {
    vaddr_t   vaddr;
    asid_t    asid;
    rob_ndx_t rob_ndx;
  } miss_t;

  typedef enum logic {PRELOAD, RUN} ctrl_state_t;

endpackage

//--- design/tlb_way_ram.sv
`include "tlb_cfg.svh"

module tlb_way_ram (
  input  logic                clk,
  input  logic                rst,
  input  logic                wr_en_i,
  input  tlb_pkg::idx_t       wr_idx_i,
  input  tlb_pkg::tlb_entry_t wr_entry_i,
  input  tlb_pkg::idx_t       lk_idx_i,
  output tlb_pkg::tlb_entry_t lk_entry_o,
  input  tlb_pkg::idx_t       rd_idx_i,
  output tlb_pkg::tlb_entry_t rd_entry_o
);

  tlb_pkg::tlb_entry_t     mem_q [`TLB_ENTRIES];    // Distributed RAM body
  logic [`TLB_ENTRIES-1:0] vld_q;                   // Valid bits live in flops so they can clear

  // Payload written on the clock, no reset on the array
  always_ff @(posedge clk) begin
    if (wr_en_i) mem_q[wr_idx_i] <= wr_entry_i;
  end

  always_ff @(posedge clk) begin
    if (rst) vld_q <= '0;                           // Every slot starts out empty
    else if (wr_en_i) vld_q[wr_idx_i] <= wr_entry_i.valid;
  end

  // Two asynchronous read ports, the valid flag comes from the flop array
  always_comb begin
    lk_entry_o       = mem_q[lk_idx_i];
    lk_entry_o.valid = vld_q[lk_idx_i];
    rd_entry_o       = mem_q[rd_idx_i];
    rd_entry_o.valid = vld_q[rd_idx_i];
  end

endmodule

//--- design/tlb_ctrl.sv
`include "tlb_cfg.svh"

module tlb_ctrl (
  input  logic             clk,
  input  logic             rst,
  input  tlb_pkg::tlb_wr_t maint_wr_i,
  output tlb_pkg::tlb_wr_t wr_o,
  output logic             init_done_o
);

  // One count value past the last entry closes the preload without a write
  localparam int CNT_W = $clog2(`PRELOAD_COUNT + 1);

  tlb_pkg::ctrl_state_t state_q;
  logic [CNT_W-1:0]     cnt_q;                      // Preload entries issued so far
  tlb_pkg::tlb_entry_t  preload_entry;

  // ============================================================
  // Boot entry builder
  // ============================================================
  // Entry k maps tag all ones to page PRELOAD_PPN+k with full rights
  always_comb begin
    preload_entry.valid = 1'b1;
    preload_entry.tag   = '1;
    preload_entry.asid  = '0;                       // Global space
    preload_entry.ppn   = tlb_pkg::ppn_t'(`PRELOAD_PPN + cnt_q);
    preload_entry.rwx   = '1;
  end

  // ============================================================
  // State machine
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= tlb_pkg::PRELOAD;
      cnt_q   <= '0;
    end else begin
      case (state_q)
        tlb_pkg::PRELOAD: begin
          cnt_q <= cnt_q + 1'b1;
          // Last preload write is already registered, move on
          if (cnt_q == CNT_W'(`PRELOAD_COUNT)) state_q <= tlb_pkg::RUN;
        end
        default: ;                                  // RUN is terminal until the next reset
      endcase
    end
  end

  // Write register feeding both ways, data lands one edge after it is captured
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_o.we <= 1'b0;
    end else if (state_q == tlb_pkg::RUN) begin
      wr_o <= maint_wr_i;                           // Maintenance passes through unchanged
    end else begin
      // Maintenance requests are dropped while the boot entries go in
      wr_o.we    <= (cnt_q < CNT_W'(`PRELOAD_COUNT));
      wr_o.way   <= 1'b0;
      wr_o.idx   <= tlb_pkg::idx_t'(`PRELOAD_FIRST + cnt_q);
      wr_o.entry <= preload_entry;
    end
  end

  assign init_done_o = (state_q == tlb_pkg::RUN);   // Stays high once reached

endmodule

//--- design/tlb_lookup.sv
`include "tlb_cfg.svh"

module tlb_lookup (
  input  logic                 clk,
  input  logic                 rst,
  input  tlb_pkg::lookup_req_t req_i,
  input  logic                 stall_i,
  input  tlb_pkg::tlb_entry_t  way0_i,
  input  tlb_pkg::tlb_entry_t  way1_i,
  output logic                 hit_v_o,
  output tlb_pkg::tlb_entry_t  hit_entry_o,
  output tlb_pkg::paddr_t      hit_paddr_o,
  output tlb_pkg::rob_ndx_t    hit_rob_o,
  output tlb_pkg::lookup_req_t miss_req_o
);

  tlb_pkg::tag_t       req_tag;
  logic                hit0;
  logic                hit1;
  logic                hit_any;
  tlb_pkg::tlb_entry_t sel_entry;

  // ============================================================
  // Tag compare
  // ============================================================
  assign req_tag = req_i.vaddr[`VADDR_W-1:`TAG_LSB];

  // A way matches only on a live entry with the same tag and address space
  assign hit0 = way0_i.valid && (way0_i.tag == req_tag) && (way0_i.asid == req_i.asid);
  assign hit1 = way1_i.valid && (way1_i.tag == req_tag) && (way1_i.asid == req_i.asid);

  assign hit_any   = hit0 | hit1;
  assign sel_entry = hit0 ? way0_i : way1_i;        // Way 0 wins when both match

  // ============================================================
  // Result stage
  // ============================================================
  always_ff @(posedge clk) begin
    if (rst) hit_v_o <= 1'b0;
    else hit_v_o <= req_i.valid && hit_any && !stall_i;  // Low for any stalled cycle
  end

  // Payload registers freeze while the consumer stalls
  always_ff @(posedge clk) begin
    if (!stall_i) begin
      hit_entry_o <= sel_entry;
      hit_paddr_o <= {sel_entry.ppn, req_i.vaddr[`IDX_LSB-1:0]};
      hit_rob_o   <= req_i.rob_ndx;
    end
  end

  // ============================================================
  // Miss request
  // ============================================================
  // Only an unstalled miss is offered, the queue filters duplicates
  always_comb begin
    miss_req_o       = req_i;
    miss_req_o.valid = req_i.valid && !hit_any && !stall_i;
  end

endmodule

//--- design/tlb_miss_queue.sv
`include "tlb_cfg.svh"

module tlb_miss_queue (
  input  logic                 clk,
  input  logic                 rst,
  input  tlb_pkg::lookup_req_t miss_req_i,
  input  logic                 miss_ack_i,
  output logic                 miss_v_o,
  output tlb_pkg::miss_t       miss_o
);

  localparam int PTR_W = `MISSQ_PTR_W;

  tlb_pkg::miss_t   slot_q [`MISSQ_DEPTH];          // Queue storage, no reset needed
  logic [PTR_W-1:0] head_q;
  logic [PTR_W-1:0] tail_q;
  logic [PTR_W:0]   count_q;                        // One extra bit to tell full from empty
  logic             full;
  logic             dup;
  logic             push;
  logic             pop;

  // ============================================================
  // Duplicate search
  // ============================================================
  // Every occupied slot is checked for the same page and address space
  always_comb begin
    logic [PTR_W-1:0] offs;
    dup  = 1'b0;
    offs = '0;
    for (int i = 0; i < `MISSQ_DEPTH; i++) begin
      offs = PTR_W'(i) - head_q;                    // Distance from the head, wraps naturally
      if (({1'b0, offs} < count_q) &&
          (slot_q[i].vaddr[`VADDR_W-1:`IDX_LSB] == miss_req_i.vaddr[`VADDR_W-1:`IDX_LSB]) &&
          (slot_q[i].asid == miss_req_i.asid)) begin
        dup = 1'b1;
      end
    end
  end

  assign full = (count_q == (PTR_W + 1)'(`MISSQ_DEPTH));
  assign push = miss_req_i.valid && !full && !dup;  // A miss to a full queue is lost
  assign pop  = miss_ack_i && miss_v_o;

  // ============================================================
  // Storage and pointers
  // ============================================================
  always_ff @(posedge clk) begin
    if (push) begin
      slot_q[tail_q] <= '{vaddr:   miss_req_i.vaddr,
                          asid:    miss_req_i.asid,
                          rob_ndx: miss_req_i.rob_ndx};
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
    end else begin
      if (push) tail_q <= tail_q + 1'b1;
      if (pop) head_q <= head_q + 1'b1;
      // Push and pop together leave the fill level alone
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: ;
      endcase
    end
  end

  // Head is shown to the page walker until it acknowledges
  assign miss_v_o = (count_q != '0);
  assign miss_o   = slot_q[head_q];

endmodule

//--- design/tlb_top.sv
`include "tlb_cfg.svh"

module tlb_top (
  input  logic                 clk,
  input  logic                 rst,
  input  tlb_pkg::tlb_wr_t     maint_wr_i,
  input  logic                 rd_way_i,
  input  tlb_pkg::idx_t        rd_idx_i,
  output tlb_pkg::tlb_entry_t  rd_entry_o,
  input  tlb_pkg::lookup_req_t req_i,
  input  logic                 stall_i,
  output logic                 hit_v_o,
  output tlb_pkg::tlb_entry_t  hit_entry_o,
  output tlb_pkg::paddr_t      hit_paddr_o,
  output tlb_pkg::rob_ndx_t    hit_rob_o,
  output logic                 miss_v_o,
  output tlb_pkg::miss_t       miss_o,
  input  logic                 miss_ack_i,
  output logic                 init_done_o
);

  tlb_pkg::tlb_wr_t     wr_q;                       // Registered write from the control machine
  tlb_pkg::idx_t        lk_idx;
  tlb_pkg::tlb_entry_t  way0_lk, way1_lk;
  tlb_pkg::tlb_entry_t  way0_rd, way1_rd;
  tlb_pkg::lookup_req_t miss_req;

  assign lk_idx = req_i.vaddr[`IDX_LSB+`TLB_IDX_W-1:`IDX_LSB];  // Set index from the request

  tlb_ctrl u_ctrl (
    .clk, .rst, .maint_wr_i, .wr_o(wr_q), .init_done_o
  );

  // ============================================================
  // Two ways, each taking only the writes aimed at it
  // ============================================================
  tlb_way_ram u_way0 (
    .clk, .rst,
    .wr_en_i(wr_q.we && !wr_q.way), .wr_idx_i(wr_q.idx), .wr_entry_i(wr_q.entry),
    .lk_idx_i(lk_idx), .lk_entry_o(way0_lk), .rd_idx_i, .rd_entry_o(way0_rd)
  );

  tlb_way_ram u_way1 (
    .clk, .rst,
    .wr_en_i(wr_q.we && wr_q.way), .wr_idx_i(wr_q.idx), .wr_entry_i(wr_q.entry),
    .lk_idx_i(lk_idx), .lk_entry_o(way1_lk), .rd_idx_i, .rd_entry_o(way1_rd)
  );

  assign rd_entry_o = rd_way_i ? way1_rd : way0_rd;  // Read-back is combinational

  tlb_lookup u_lookup (
    .clk, .rst, .req_i, .stall_i, .way0_i(way0_lk), .way1_i(way1_lk),
    .hit_v_o, .hit_entry_o, .hit_paddr_o, .hit_rob_o, .miss_req_o(miss_req)
  );

  tlb_miss_queue u_missq (
    .clk, .rst, .miss_req_i(miss_req), .miss_ack_i, .miss_v_o, .miss_o
  );

endmodule

//--- testbench/tlb_asserts.sv
module tlb_asserts (
  input logic           clk,
  input logic           rst,
  input logic           init_done_i,
  input logic           stall_i,
  input logic           hit_v_i,
  input logic           miss_v_i,
  input logic           miss_ack_i,
  input tlb_pkg::miss_t miss_i
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned fail_cnt = 0;                        // Number of failed properties so far

  // Once the boot preload is over the buffer stays ready
  init_done_sticky: assert property (@(posedge clk) disable iff (rst)
    init_done_i |=> init_done_i)
    else begin
      $error("init_done_o fell after it had risen");
      fail_cnt++;
    end

  // A stalled cycle never produces a result on the next one
  stall_blocks_hit: assert property (@(posedge clk) disable iff (rst)
    stall_i |=> !hit_v_i)
    else begin
      $error("hit_v_o high in the cycle after a stall");
      fail_cnt++;
    end

  // The walker sees the same head until it acknowledges
  miss_head_stable: assert property (@(posedge clk) disable iff (rst)
    (miss_v_i && !miss_ack_i) |=> (miss_v_i && $stable(miss_i)))
    else begin
      $error("miss_o changed while waiting for miss_ack_i");
      fail_cnt++;
    end

endmodule

bind tlb_top tlb_asserts u_asserts (
  .clk(clk), .rst(rst), .init_done_i(init_done_o), .stall_i(stall_i), .hit_v_i(hit_v_o),
  .miss_v_i(miss_v_o), .miss_ack_i(miss_ack_i), .miss_i(miss_o)
);

//--- testbench/tb_tlb.sv
`include "tlb_cfg.svh"

module tb_tlb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CLK_PERIOD     = 40;
  localparam int N_WRITES       = 200;
  localparam int N_LOOKUPS      = 300;
  // Reset, preload, then each phase with its queue drain
  localparam int PLANNED_CYCLES = 16 + 16 + 40 + 2 * N_WRITES + N_LOOKUPS + 20 + 50;

  logic                 clk;
  logic                 rst;
  tlb_pkg::tlb_wr_t     maint_wr;
  logic                 rd_way;
  tlb_pkg::idx_t        rd_idx;
  tlb_pkg::tlb_entry_t  rd_entry;
  tlb_pkg::lookup_req_t req;
  logic                 stall;
  logic                 hit_v;
  tlb_pkg::tlb_entry_t  hit_entry;
  tlb_pkg::paddr_t      hit_paddr;
  tlb_pkg::rob_ndx_t    hit_rob;
  logic                 miss_v;
  tlb_pkg::miss_t       miss;
  logic                 miss_ack;
  logic                 init_done;

  tlb_pkg::tlb_entry_t  ref_way [2][`TLB_ENTRIES];  // Expected contents of both ways
  tlb_pkg::miss_t       ref_q [$];                  // Expected miss queue, head first
  int                   written [$];                // Way times entries plus index of each write

  tlb_pkg::tlb_entry_t  held_entry;                 // Result that a stall must keep in place
  tlb_pkg::paddr_t      held_paddr;
  tlb_pkg::rob_ndx_t    held_rob;
  logic                 held_ok;                    // Set while the held result is known

  tlb_top i_dut (
    .clk, .rst, .maint_wr_i(maint_wr), .rd_way_i(rd_way), .rd_idx_i(rd_idx),
    .rd_entry_o(rd_entry), .req_i(req), .stall_i(stall), .hit_v_o(hit_v),
    .hit_entry_o(hit_entry), .hit_paddr_o(hit_paddr), .hit_rob_o(hit_rob),
    .miss_v_o(miss_v), .miss_o(miss), .miss_ack_i(miss_ack), .init_done_o(init_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ============================================================
  // Reference model helpers
  // ============================================================
  function automatic logic way_match(input tlb_pkg::tlb_entry_t e, input tlb_pkg::vaddr_t va,
                                     input tlb_pkg::asid_t asid);
    return e.valid && (e.tag == va[`VADDR_W-1:`TAG_LSB]) && (e.asid == asid);
  endfunction

  // Small tag and asid ranges so that both ways often collide on one page
  function automatic tlb_pkg::tlb_entry_t random_entry();
    tlb_pkg::tlb_entry_t e;
    e.valid = ($urandom_range(3) != 0);
    e.tag   = tlb_pkg::tag_t'($urandom_range(7));
    e.asid  = tlb_pkg::asid_t'($urandom_range(3));
    e.ppn   = tlb_pkg::ppn_t'($urandom);
    e.rwx   = tlb_pkg::rwx_t'($urandom);
    return e;
  endfunction

  task automatic check(input string name, input logic [63:0] exp_val,
                       input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("Mismatch %s: expected %h, actual %h", name, exp_val, act_val);
      $display("SOME TESTS FAILED");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // One clock of lookup and acknowledge traffic, entered 2 ns after an edge
  task automatic run_cycle(input string name, input tlb_pkg::lookup_req_t r, input logic stl,
                           input logic ack);
    tlb_pkg::idx_t       idx;
    tlb_pkg::tlb_entry_t e0;
    tlb_pkg::tlb_entry_t e1;
    tlb_pkg::tlb_entry_t exp_e;
    tlb_pkg::paddr_t     exp_pa;
    tlb_pkg::miss_t      m;
    logic                hit0;
    logic                hit1;
    logic                exp_hit;
    logic                push;
    idx     = r.vaddr[`IDX_LSB+`TLB_IDX_W-1:`IDX_LSB];
    e0      = ref_way[0][idx];
    e1      = ref_way[1][idx];
    hit0    = way_match(e0, r.vaddr, r.asid);
    hit1    = way_match(e1, r.vaddr, r.asid);
    exp_hit = r.valid && (hit0 || hit1) && !stl;
    exp_e   = hit0 ? e0 : e1;                       // Way 0 has priority
    exp_pa  = {exp_e.ppn, r.vaddr[`IDX_LSB-1:0]};   // Page number over the page offset
    push    = r.valid && !hit0 && !hit1 && !stl && (ref_q.size() < `MISSQ_DEPTH);
    // A page with the same asid already waiting is not queued again
    foreach (ref_q[i]) begin
      if ((ref_q[i].vaddr[`VADDR_W-1:`IDX_LSB] == r.vaddr[`VADDR_W-1:`IDX_LSB]) &&
          (ref_q[i].asid == r.asid)) push = 1'b0;
    end
    m.vaddr   = r.vaddr;
    m.asid    = r.asid;
    m.rob_ndx = r.rob_ndx;
    req      = r;
    stall    = stl;
    miss_ack = ack;
    @(posedge clk);
    if (ack && (ref_q.size() != 0)) void'(ref_q.pop_front());  // Pop sees the old head
    if (push) ref_q.push_back(m);
    #1;
    // A stalled cycle keeps the last result on the payload outputs
    if (stl && held_ok) begin
      check({name, " held hit_entry"}, held_entry, hit_entry);
      check({name, " held hit_paddr"}, held_paddr, hit_paddr);
      check({name, " held hit_rob"}, held_rob, hit_rob);
    end
    check({name, " hit_v"}, exp_hit, hit_v);
    if (exp_hit) begin
      check({name, " hit_entry"}, exp_e, hit_entry);
      check({name, " hit_paddr"}, exp_pa, hit_paddr);
      check({name, " hit_rob"}, r.rob_ndx, hit_rob);
      held_entry = exp_e;
      held_paddr = exp_pa;
      held_rob   = r.rob_ndx;
    end
    if (!stl) held_ok = exp_hit;                    // A miss reloads the payload with no meaning
    check({name, " miss_v"}, ref_q.size() != 0, miss_v);
    if (ref_q.size() != 0) check({name, " miss head"}, ref_q[0], miss);
    #1;
  endtask

  task automatic drain_queue(input string name, output int popped);
    tlb_pkg::lookup_req_t idle;
    idle   = '0;
    popped = 0;
    // Pops follow the valid of the DUT and stop one past the queue depth
    while (miss_v && (popped <= `MISSQ_DEPTH)) begin
      run_cycle(name, idle, 1'b0, 1'b1);
      popped++;
    end
    run_cycle(name, idle, 1'b0, 1'b0);              // Queue must still read empty
  endtask

  // Write lands one edge after capture, then the read port shows it
  task automatic write_and_read(input logic way, input tlb_pkg::idx_t idx,
                                input tlb_pkg::tlb_entry_t e);
    maint_wr.we    = 1'b1;
    maint_wr.way   = way;
    maint_wr.idx   = idx;
    maint_wr.entry = e;
    rd_way         = way;
    rd_idx         = idx;
    held_ok        = 1'b0;                          // Idle lookups reload the result stage
    @(posedge clk);
    #2 maint_wr.we = 1'b0;
    @(posedge clk);
    ref_way[way][idx] = e;
    written.push_back(int'(way) * `TLB_ENTRIES + int'(idx));
    #1 check("readback", ref_way[way][idx], rd_entry);
    #1;
  endtask

  initial begin
    #((PLANNED_CYCLES + 200) * CLK_PERIOD);
    $display("Watchdog expired before the tests finished");
    $display("SOME TESTS FAILED");
    $fatal(1, "Simulation timed out");
  end

  // Bound assertion failures end the run at once
  initial begin
    wait (i_dut.u_asserts.fail_cnt != 0);
    $display("A bound assertion failed");
    $display("SOME TESTS FAILED");
    $fatal(1, "Assertion failure during the run");
  end

  // ============================================================
  // Test sequence
  // ============================================================
  initial begin
    tlb_pkg::lookup_req_t r;
    tlb_pkg::tlb_entry_t  e;
    int                   code;
    int                   popped;
    void'($urandom(32'hf299));
    rst      = 1'b1;
    maint_wr = '0;
    rd_way   = 1'b0;
    rd_idx   = '0;
    req      = '0;
    stall    = 1'b0;
    miss_ack = 1'b0;
    held_ok  = 1'b0;
    foreach (ref_way[w, i]) ref_way[w][i] = '0;
    repeat (16) @(posedge clk);
    #2 rst = 1'b0;
    check("reset hit_v", 1'b0, hit_v);
    check("reset miss_v", 1'b0, miss_v);
    check("reset init_done", 1'b0, init_done);
    while (!init_done) begin
      @(posedge clk);
      #1;
    end
    #1;
    // Boot mapping of the top pages into way 0
    for (int k = 0; k < `PRELOAD_COUNT; k++) begin
      ref_way[0][`PRELOAD_FIRST + k] = '{valid: 1'b1, tag: '1, asid: '0,
                                         ppn: tlb_pkg::ppn_t'(`PRELOAD_PPN + k), rwx: 3'b111};
    end

    // Preloaded pages hit, the same tag elsewhere misses
    for (int k = 0; k < `PRELOAD_COUNT; k++) begin
      r = '{valid: 1'b1, vaddr: {9'h1ff, tlb_pkg::idx_t'(`PRELOAD_FIRST + k), 16'($urandom)},
            asid: '0, rob_ndx: tlb_pkg::rob_ndx_t'($urandom)};
      run_cycle("preload_hit", r, 1'b0, 1'b0);
      check("preload_ppn", `PRELOAD_PPN + k, hit_paddr[`PPN_W+`IDX_LSB-1:`IDX_LSB]);
    end
    for (int k = 0; k < `PRELOAD_COUNT; k++) begin
      r = '{valid: 1'b1, vaddr: {9'h1ff, tlb_pkg::idx_t'(k), 16'($urandom)},
            asid: '0, rob_ndx: tlb_pkg::rob_ndx_t'($urandom)};
      run_cycle("preload_miss", r, 1'b0, 1'b0);
    end
    drain_queue("preload_drain", popped);
    check("preload_drain count", `PRELOAD_COUNT, popped);

    // Maintenance writes with read-back
    for (int n = 0; n < N_WRITES; n++) begin
      write_and_read(1'($urandom), tlb_pkg::idx_t'($urandom), random_entry());
    end

    // Random lookups, half aimed at pages that were written
    for (int n = 0; n < N_LOOKUPS; n++) begin
      if ($urandom_range(1) == 0) begin
        code    = written[$urandom_range(written.size() - 1)];
        e       = ref_way[code / `TLB_ENTRIES][code % `TLB_ENTRIES];
        r.vaddr = {e.tag, tlb_pkg::idx_t'(code % `TLB_ENTRIES), 16'($urandom)};
        r.asid  = e.asid;
      end else begin
        r.vaddr = $urandom;
        r.asid  = tlb_pkg::asid_t'($urandom_range(3));
      end
      r.valid   = ($urandom_range(7) != 0);
      r.rob_ndx = tlb_pkg::rob_ndx_t'($urandom);
      run_cycle("random_lookup", r, $urandom_range(3) == 0, 1'($urandom));
    end
    drain_queue("random_drain", popped);

    // Second miss to a waiting page is filtered
    r = '{valid: 1'b1, vaddr: {9'h1f0, 7'd5, 16'h1234}, asid: 8'h3, rob_ndx: 6'd1};
    run_cycle("dup_first", r, 1'b0, 1'b0);
    r.vaddr[15:0] = 16'hbeef;
    r.rob_ndx     = 6'd2;
    run_cycle("dup_second", r, 1'b0, 1'b0);
    drain_queue("dup_drain", popped);
    check("dup_drain count", 1, popped);

    // Tags above the written range always miss, so the queue overflows
    for (int n = 0; n < `MISSQ_DEPTH + 4; n++) begin
      r = '{valid: 1'b1, vaddr: {9'h100 | 9'(n), tlb_pkg::idx_t'(n), 16'($urandom)},
            asid: tlb_pkg::asid_t'($urandom), rob_ndx: tlb_pkg::rob_ndx_t'(n)};
      run_cycle("overflow_fill", r, 1'b0, 1'b0);
    end
    drain_queue("overflow_drain", popped);
    check("overflow_drain count", `MISSQ_DEPTH, popped);

    if (i_dut.u_asserts.fail_cnt == 0) begin
      $display("ALL TESTS PASSED");
      $finish;
    end else begin
      $display("Bound assertions failed %0d times", i_dut.u_asserts.fail_cnt);
      $display("SOME TESTS FAILED");
      $fatal(1, "Assertion failures during the run");
    end
  end

endmodule

//--- src.f
+incdir+design
design/tlb_pkg.sv
design/tlb_way_ram.sv
design/tlb_ctrl.sv
design/tlb_lookup.sv
design/tlb_miss_queue.sv
design/tlb_top.sv
testbench/tlb_asserts.sv
testbench/tb_tlb.sv

//--- Bender.yml
package:
  name: tlb

sources:
  - include_dirs:
      - design
    files:
      - design/tlb_pkg.sv
      - design/tlb_way_ram.sv
      - design/tlb_ctrl.sv
      - design/tlb_lookup.sv
      - design/tlb_miss_queue.sv
      - design/tlb_top.sv
  - target: test
    include_dirs:
      - design
    files:
      - testbench/tlb_asserts.sv
      - testbench/tb_tlb.sv
